// File: hw/dat_in_framer.sv
`timescale 1ns/10ps

module dat_in_framer
    import sd_readback_pkg::*;
#(
    parameter int block_words = 256
) (
    input  logic         sd_datInWrite_clk,
    input  logic         sd_datInWrite_rst_,

    input  logic         dat_in_trigger,
    input  sd_word_t     dat_in_data,
    output logic         dat_in_ready,

    input  logic         full,
    output logic         push,
    output rd_word_t     push_word,

    output access_mode_t cmd6_access_mode,
    output logic         cmd6_valid
);

    localparam int cnt_w = $clog2(block_words);

    // The capture word has to fall inside a block
    if (block_words <= cmd6_mode_word_idx) begin : g_block_words_check
        $error("block_words must be greater than %0d", cmd6_mode_word_idx);
    end

    logic [cnt_w-1:0] word_cnt;     // Word index within the current block
    logic             first_block;
    logic             accept;
    logic             block_end;
    logic             mode_word;

    // ====================
    // Input handshake
    // ====================
    assign dat_in_ready = !full;
    assign accept       = dat_in_trigger && dat_in_ready;

    assign block_end = (word_cnt == cnt_w'(block_words - 1));
    assign mode_word = first_block && (word_cnt == cnt_w'(cmd6_mode_word_idx));

    // Accepted words go straight into the FIFO
    assign push           = accept;
    assign push_word.data = dat_in_data;
    assign push_word.last = block_end;

    // ====================
    // Block counter
    // ====================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            word_cnt    <= '0;
            first_block <= 1'b1;
        end else if (accept) begin
            if (block_end) begin
                word_cnt    <= '0;
                first_block <= 1'b0;    // Capture window closes here
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    // ====================
    // CMD6 access mode
    // ====================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            cmd6_access_mode <= '0;
            cmd6_valid       <= 1'b0;
        end else if (accept && mode_word) begin
            cmd6_access_mode <= dat_in_data[cmd6_mode_lsb +: access_mode_w];
            cmd6_valid       <= 1'b1;
        end
    end

    // Source must hold off while the buffer is full
    a_no_trigger_when_busy : assert property (
        @(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
        dat_in_trigger |-> dat_in_ready
    ) else $error("dat_in_trigger while dat_in_ready is low");

endmodule

// File: hw/readout_sender.sv
`timescale 1ns/10ps

module readout_sender
    import sd_readback_pkg::*;
(
    input  logic     sd_datInWrite_clk,
    input  logic     sd_datInWrite_rst_,

    input  logic     empty,
    input  rd_word_t pop_word,
    output logic     pop,

    output logic     rd_req,
    input  logic     rd_ack,
    output rd_word_t rd_word
);

    typedef enum logic [1:0] {
        st_idle,
        st_request,     // req high, word on rd_word
        st_ack_low      // Waiting for the receiver to drop ack
    } state_t;

    state_t state;

    // ====================
    // Handshake FSM
    // ====================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (!empty) state <= st_request;
                end
                st_request: begin
                    if (rd_ack) state <= st_ack_low;   // Word taken
                end
                st_ack_low: begin
                    if (!rd_ack) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign rd_req = (state == st_request);

    // Head leaves the FIFO on the edge that sees ack
    assign pop = rd_req && rd_ack;

    // Output word is loaded as req goes up
    always_ff @(posedge sd_datInWrite_clk) begin
        if (state == st_idle && !empty) begin
            rd_word <= pop_word;
        end
    end

    a_word_stable : assert property (
        @(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
        rd_req |=> $stable(rd_word)
    ) else $error("rd_word changed while rd_req high");

endmodule

// File: hw/sd_readback.sv
`timescale 1ns/10ps

module sd_readback
    import sd_readback_pkg::*;
#(
    parameter int block_words = 256,    // 512-byte SD block
    parameter int fifo_depth  = 16
) (
    input  logic         sd_datInWrite_clk,
    input  logic         sd_datInWrite_rst_,

    // Word stream from the SD controller
    input  logic         dat_in_trigger,
    input  sd_word_t     dat_in_data,
    output logic         dat_in_ready,

    // Four-phase readout
    output logic         rd_req,
    input  logic         rd_ack,
    output rd_word_t     rd_word,

    output access_mode_t cmd6_access_mode,
    output logic         cmd6_valid
);

    logic     push;
    rd_word_t push_word;
    logic     full;
    logic     pop;
    rd_word_t pop_word;
    logic     empty;

    // ====================
    // Producer
    // ====================
    dat_in_framer #(
        .block_words(block_words)
    ) i_dat_in_framer (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .dat_in_trigger     (dat_in_trigger),
        .dat_in_data        (dat_in_data),
        .dat_in_ready       (dat_in_ready),
        .full               (full),
        .push               (push),
        .push_word          (push_word),
        .cmd6_access_mode   (cmd6_access_mode),
        .cmd6_valid         (cmd6_valid)
    );

    // ====================
    // Buffer
    // ====================
    word_fifo #(
        .payload_t  (rd_word_t),
        .fifo_depth (fifo_depth)
    ) i_word_fifo (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .push               (push),
        .push_word          (push_word),
        .full               (full),
        .pop                (pop),
        .pop_word           (pop_word),
        .empty              (empty)
    );

    // ====================
    // Consumer
    // ====================
    readout_sender i_readout_sender (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .empty              (empty),
        .pop_word           (pop_word),
        .pop                (pop),
        .rd_req             (rd_req),
        .rd_ack             (rd_ack),
        .rd_word            (rd_word)
    );

endmodule

// File: hw/sd_readback_pkg.sv
package sd_readback_pkg;

    // ====================
    // SD data words
    // ====================
    localparam int sd_word_w = 16;

    typedef logic [sd_word_w-1:0] sd_word_t;

    // One buffered word plus its block-end marker
    typedef struct packed {
        sd_word_t data;
        logic     last;     // Final word of a block
    } rd_word_t;

    // ====================
    // CMD6 status block
    // ====================
    localparam int access_mode_w = 4;

    typedef logic [access_mode_w-1:0] access_mode_t;

    // Access mode sits in bits 11:8 of word 8 of the CMD6 status block
    localparam int cmd6_mode_word_idx = 8;
    localparam int cmd6_mode_lsb      = 8;

endpackage

// File: hw/word_fifo.sv
`timescale 1ns/10ps

module word_fifo #(
    parameter type payload_t  = logic,
    parameter int  fifo_depth = 16
) (
    input  logic     sd_datInWrite_clk,
    input  logic     sd_datInWrite_rst_,

    input  logic     push,
    input  payload_t push_word,
    output logic     full,

    input  logic     pop,
    output payload_t pop_word,
    output logic     empty
);

    localparam int addr_w = $clog2(fifo_depth);

    if ((1 << addr_w) != fifo_depth || fifo_depth < 2) begin : g_depth_check
        $error("fifo_depth must be a power of 2, got %0d", fifo_depth);
    end

    // Extra MSB tells a full buffer from an empty one
    typedef logic [addr_w:0] ptr_t;

    payload_t mem [fifo_depth];
    ptr_t     wr_ptr;
    ptr_t     rd_ptr;
    logic     do_push;
    logic     do_pop;

    // ====================
    // Status flags
    // ====================
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                   (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Show-ahead head entry
    assign pop_word = mem[rd_ptr[addr_w-1:0]];

    // ====================
    // Storage
    // ====================
    always_ff @(posedge sd_datInWrite_clk) begin
        if (do_push) begin
            mem[wr_ptr[addr_w-1:0]] <= push_word;
        end
    end

    // ====================
    // Pointers
    // ====================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Writer is expected to watch full
    a_no_push_when_full : assert property (
        @(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
        push |-> !full
    ) else $error("push while FIFO full");

    // Reader is expected to watch empty
    a_no_pop_when_empty : assert property (
        @(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
        pop |-> !empty
    ) else $error("pop while FIFO empty");

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the sd_readback testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

top=sd_readback_tb
log=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --top-module "$top" -f sd_readback.f

./obj_dir/V"$top" | tee "$log"

if grep -qF "** PASS **" "$log"; then
    echo "Simulation passed, see $log"
else
    echo "Simulation did not pass, see $log"
    exit 1
fi

// File: sd_readback.f
hw/sd_readback_pkg.sv
hw/dat_in_framer.sv
hw/word_fifo.sv
hw/readout_sender.sv
hw/sd_readback.sv
+incdir+verification
verification/sd_readback_tb.sv

// File: verification/sd_readback_tasks.svh
`ifndef sd_readback_tasks_svh
`define sd_readback_tasks_svh

// ====================
// Reporting
// ====================
function automatic void value_mismatch(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    errors++;
endfunction

function automatic void protocol_error(input string msg);
    $display("Error at %0t: %s", $time, msg);
    errors++;
endfunction

function automatic void record_result(input string name, input int err0);
    tests_run++;
    if (errors == err0) begin
        $display("%s: passed", name);
    end else begin
        tests_failed++;
        $display("%s: failed with %0d errors", name, errors - err0);
    end
endfunction

// ====================
// Stimulus
// ====================
task automatic idle_cycles(input int n);
    repeat (n) begin
        @(posedge sd_datInWrite_clk);
        #drive_delay;
    end
endtask

// Offers one word and queues what should come out for it
task automatic send_word(input sd_word_t data);
    rd_word_t exp_word;
    while (!dat_in_ready) begin
        saw_not_ready = 1'b1;
        idle_cycles(1);
    end
    exp_word.data = data;
    exp_word.last = (sent_total % block_words) == block_words - 1;
    if (sent_total == cmd6_mode_word_idx) mode_word_data = data;
    exp_q.push_back(exp_word);
    sent_total++;
    dat_in_trigger = 1'b1;
    dat_in_data    = data;
    idle_cycles(1);     // Accepted on this edge
    dat_in_trigger = 1'b0;
endtask

task automatic wait_drain();
    int cycles;
    cycles = 0;
    while ((exp_q.size() != 0 || rd_req) && cycles < drain_limit) begin
        idle_cycles(1);
        cycles++;
    end
    if (exp_q.size() != 0) protocol_error("output stalled with words still outstanding");
    idle_cycles(2);     // Let ack fall and the sender return to idle
endtask

// Receiver side of the four-phase output
task automatic respond_loop();
    int       delay;
    rd_word_t exp_word;
    forever begin
        idle_cycles(1);
        if (rd_req) begin
            delay = ack_random ? int'($urandom_range(0, ack_delay)) : ack_delay;
            idle_cycles(delay);
            if (exp_q.size() == 0) begin
                protocol_error("rd_req raised with no word outstanding");
            end else begin
                exp_word = exp_q.pop_front();
                if (rd_word !== exp_word) begin
                    value_mismatch($sformatf("rd_word %h/%b, expected %h/%b",
                                             rd_word.data, rd_word.last,
                                             exp_word.data, exp_word.last));
                end
            end
            rx_total++;
            if (rd_word.last) last_total++;
            rd_ack = 1'b1;
            do begin
                idle_cycles(1);
            end while (rd_req);
            rd_ack = 1'b0;
        end
    end
endtask

`endif

// File: verification/sd_readback_tb.sv
`timescale 1ns/10ps

module sd_readback_tb
    import sd_readback_pkg::*;
();

    localparam int block_words   = 32;
    localparam int fifo_depth    = 8;
    localparam int clk_half      = 20;     // 40 ns period
    localparam int drive_delay   = 2;
    localparam int reset_cycles  = 16;
    localparam int max_ack_delay = 30;
    localparam int drain_limit   = 4000;

    // Two blocks, the back-pressure burst, three random blocks
    localparam int total_words     = 2 * block_words + 20 + 3 * block_words;
    localparam int watchdog_cycles = total_words * (max_ack_delay + 6) + 500;

    logic         sd_datInWrite_clk;
    logic         sd_datInWrite_rst_;
    logic         dat_in_trigger;
    sd_word_t     dat_in_data;
    logic         dat_in_ready;
    logic         rd_req;
    logic         rd_ack;
    rd_word_t     rd_word;
    access_mode_t cmd6_access_mode;
    logic         cmd6_valid;

    // Scoreboard state
    rd_word_t exp_q[$];
    int       sent_total    = 0;
    int       rx_total      = 0;
    int       last_total    = 0;
    sd_word_t mode_word_data = '0;  // 9th word since reset
    int       ack_delay     = 0;
    bit       ack_random    = 1'b0;
    bit       saw_not_ready = 1'b0;
    int       errors        = 0;
    int       tests_run     = 0;
    int       tests_failed  = 0;

    `include "sd_readback_tasks.svh"

    sd_readback #(
        .block_words (block_words),
        .fifo_depth  (fifo_depth)
    ) i_sd_readback (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .dat_in_trigger     (dat_in_trigger),
        .dat_in_data        (dat_in_data),
        .dat_in_ready       (dat_in_ready),
        .rd_req             (rd_req),
        .rd_ack             (rd_ack),
        .rd_word            (rd_word),
        .cmd6_access_mode   (cmd6_access_mode),
        .cmd6_valid         (cmd6_valid)
    );

    initial sd_datInWrite_clk = 1'b0;
    always #clk_half sd_datInWrite_clk = ~sd_datInWrite_clk;

    initial begin
        rd_ack = 1'b0;
        respond_loop();
    end

    initial begin
        repeat (watchdog_cycles) @(posedge sd_datInWrite_clk);
        $display("Timeout expired after %0d cycles, the tests did not finish", watchdog_cycles);
        $display("** FAIL **");
        $finish;
    end

    // ====================
    // Directed tests
    // ====================
    task automatic reset_state();
        int err0;
        err0 = errors;
        if (rd_req !== 1'b0) value_mismatch($sformatf("rd_req is %b after reset", rd_req));
        if (cmd6_valid !== 1'b0) begin
            value_mismatch($sformatf("cmd6_valid is %b after reset", cmd6_valid));
        end
        if (dat_in_ready !== 1'b1) begin
            value_mismatch($sformatf("dat_in_ready is %b after reset", dat_in_ready));
        end
        record_result("reset state", err0);
    endtask

    task automatic one_block_in_order();
        int err0;
        int rx0;
        int last0;
        err0  = errors;
        rx0   = rx_total;
        last0 = last_total;
        ack_random = 1'b0;
        ack_delay  = 0;
        for (int i = 0; i < block_words; i++) begin
            send_word(sd_word_t'(i * 16'h0101));   // Counting in both bytes
        end
        wait_drain();
        if (rx_total - rx0 != block_words) begin
            value_mismatch($sformatf("%0d words out, expected %0d",
                                     rx_total - rx0, block_words));
        end
        if (last_total - last0 != 1) begin
            value_mismatch($sformatf("%0d last flags in one block", last_total - last0));
        end
        record_result("one block in order", err0);
    endtask

    task automatic cmd6_capture();
        int           err0;
        access_mode_t exp_mode;
        err0     = errors;
        exp_mode = mode_word_data[cmd6_mode_lsb +: $bits(access_mode_t)];
        if (cmd6_valid !== 1'b1) value_mismatch("cmd6_valid low after the first block");
        if (cmd6_access_mode !== exp_mode) begin
            value_mismatch($sformatf("access mode %h, expected %h",
                                     cmd6_access_mode, exp_mode));
        end
        // Second block carries a different mode field in its 9th word
        for (int i = 0; i < block_words; i++) begin
            send_word(sd_word_t'(~(i * 16'h0101)));
        end
        wait_drain();
        if (cmd6_valid !== 1'b1) value_mismatch("cmd6_valid dropped after the second block");
        if (cmd6_access_mode !== exp_mode) begin
            value_mismatch($sformatf("access mode changed to %h, expected %h",
                                     cmd6_access_mode, exp_mode));
        end
        record_result("cmd6 capture", err0);
    endtask

    task automatic back_pressure();
        int err0;
        int rx0;
        err0 = errors;
        rx0  = rx_total;
        ack_random    = 1'b0;
        ack_delay     = max_ack_delay;
        saw_not_ready = 1'b0;
        for (int i = 0; i < 20; i++) begin
            send_word(sd_word_t'(16'h4000 + i * 16'h0013));
        end
        wait_drain();
        if (!saw_not_ready) value_mismatch("dat_in_ready never went low under a slow ack");
        if (rx_total - rx0 != 20) begin
            value_mismatch($sformatf("%0d words out, expected 20", rx_total - rx0));
        end
        record_result("back-pressure", err0);
    endtask

    task automatic random_traffic();
        int err0;
        int rx0;
        err0 = errors;
        rx0  = rx_total;
        ack_random = 1'b1;
        ack_delay  = 5;     // Upper bound of the random delay
        for (int i = 0; i < 3 * block_words; i++) begin
            idle_cycles(int'($urandom_range(0, 3)));
            send_word(sd_word_t'($urandom()));
        end
        wait_drain();
        if (rx_total - rx0 != 3 * block_words) begin
            value_mismatch($sformatf("%0d words out, expected %0d",
                                     rx_total - rx0, 3 * block_words));
        end
        record_result("random traffic", err0);
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        void'($urandom(32'hd94f));
        sd_datInWrite_rst_ = 1'b0;
        dat_in_trigger     = 1'b0;
        dat_in_data        = '0;
        repeat (reset_cycles) @(posedge sd_datInWrite_clk);
        #drive_delay;
        sd_datInWrite_rst_ = 1'b1;
        idle_cycles(1);

        reset_state();
        one_block_in_order();
        cmd6_capture();
        back_pressure();
        random_traffic();

        $display("Tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
